// File: rtl/varith_decoder.sv
`timescale 1ns/1ps
// Integer arithmetic func6 decoder
// Maps func6 of the OPIVV and OPIVX groups onto a backend operation

module varith_decoder (
  input  logic [5:0]                  func6_i,
  input  vdisp_pkg::varith_variant_e  variant_i,
  output vdisp_pkg::vop_e             op_o,
  output logic                        illegal_o
);

  // func6 encodings
  localparam logic [5:0] F6_VADD  = 6'b000000;
  localparam logic [5:0] F6_VSUB  = 6'b000010;
  localparam logic [5:0] F6_VRSUB = 6'b000011;
  localparam logic [5:0] F6_VMINU = 6'b000100;
  localparam logic [5:0] F6_VMIN  = 6'b000101;
  localparam logic [5:0] F6_VMAXU = 6'b000110;
  localparam logic [5:0] F6_VMAX  = 6'b000111;
  localparam logic [5:0] F6_VAND  = 6'b001001;
  localparam logic [5:0] F6_VOR   = 6'b001010;
  localparam logic [5:0] F6_VXOR  = 6'b001011;

  always_comb begin
    op_o      = vdisp_pkg::VADD;
    illegal_o = 1'b0;

    case (func6_i)
      F6_VADD:  op_o = vdisp_pkg::VADD;
      F6_VSUB:  op_o = vdisp_pkg::VSUB;
      F6_VRSUB: begin
        // Reverse subtract has no vector-vector form
        op_o      = vdisp_pkg::VRSUB;
        illegal_o = (variant_i != vdisp_pkg::VX);
      end
      F6_VMINU: op_o = vdisp_pkg::VMINU;
      F6_VMIN:  op_o = vdisp_pkg::VMIN;
      F6_VMAXU: op_o = vdisp_pkg::VMAXU;
      F6_VMAX:  op_o = vdisp_pkg::VMAX;
      F6_VAND:  op_o = vdisp_pkg::VAND;
      F6_VOR:   op_o = vdisp_pkg::VOR;
      F6_VXOR:  op_o = vdisp_pkg::VXOR;
      default:  illegal_o = 1'b1;
    endcase
  end

endmodule

// File: rtl/vcfg_if.sv
`timescale 1ns/1ps
// Configuration bus between dispatch control and the vector CSR unit
// Carries the instruction in one direction and the CSR state back

interface vcfg_if;
  // Driven by the dispatch control
  logic              cfg_sel;
  logic              commit;
  logic [31:0]       insn;
  vdisp_pkg::xlen_t  rs1;
  vdisp_pkg::xlen_t  rs2;

  // Driven by the configuration unit
  vdisp_pkg::xlen_t  result;
  logic              error;
  vdisp_pkg::vtype_t vtype;
  vdisp_pkg::xlen_t  vl;
  logic              vill;

  modport ctrl (
    output cfg_sel, commit, insn, rs1, rs2,
    input  result, error, vtype, vl, vill
  );

  modport cfg (
    input  cfg_sel, commit, insn, rs1, rs2,
    output result, error, vtype, vl, vill
  );
endinterface

// File: rtl/vcfg_unit.sv
`timescale 1ns/1ps
// Vector configuration unit
// Holds vtype, vl and vstart, executes vsetvl(i) and the vector CSR accesses

module vcfg_unit #(
  parameter int Vlen = 128
) (
  input logic clk_i,
  input logic rst_ni,
  vcfg_if.cfg cfg
);

  localparam vdisp_pkg::xlen_t VLENB = vdisp_pkg::xlen_t'(Vlen / 8);

  vdisp_pkg::vtype_t vtype_q, vtype_d;
  vdisp_pkg::xlen_t  vl_q, vl_d;
  vdisp_pkg::xlen_t  vstart_q, vstart_d;

  logic [6:0]        opcode;
  logic [2:0]        func3;
  logic [4:0]        rs1_field;
  logic [4:0]        rd_field;
  logic [11:0]       csr_addr;
  vdisp_pkg::vtype_t vtype_new;
  logic              cfg_form_ok;
  logic [2:0]        lmul_mag;
  logic [31:0]       sew_bits;
  logic              vtype_illegal;
  vdisp_pkg::xlen_t  vlmax;
  vdisp_pkg::xlen_t  csr_operand;
  vdisp_pkg::xlen_t  vtype_csr;

  assign opcode    = cfg.insn[6:0];
  assign func3     = cfg.insn[14:12];
  assign rs1_field = cfg.insn[19:15];
  assign rd_field  = cfg.insn[11:7];
  assign csr_addr  = cfg.insn[31:20];

  // vsetvli takes zimm, vsetvl takes rs2
  always_comb begin
    cfg_form_ok = 1'b1;
    if (!cfg.insn[31]) begin
      vtype_new = vdisp_pkg::vtype_t'({1'b0, cfg.insn[27:20]});
    end else if (cfg.insn[31:25] == 7'h40) begin
      vtype_new = vdisp_pkg::vtype_t'({1'b0, cfg.rs2[7:0]});
    end else begin
      vtype_new   = vdisp_pkg::VTYPE_RESET;
      cfg_form_ok = 1'b0;
    end
  end

  // Magnitude of a fractional LMUL exponent
  assign lmul_mag = 3'd0 - vtype_new.vlmul;
  assign sew_bits = 32'd8 << vtype_new.vsew;

  assign vtype_illegal = (vtype_new.vsew > vdisp_pkg::EW64) ||
                         (vtype_new.vlmul == 3'b100) ||
                         (vtype_new.vlmul[2] && ((sew_bits << lmul_mag) > vdisp_pkg::ELEN));

  // VLMAX = LMUL * VLEN / SEW
  assign vlmax = vtype_new.vlmul[2] ? ((VLENB >> vtype_new.vsew) >> lmul_mag)
                                    : ((VLENB >> vtype_new.vsew) << vtype_new.vlmul);

  // Immediate forms use the rs1 field as a zero-extended value
  assign csr_operand = func3[2] ? vdisp_pkg::xlen_t'(rs1_field) : cfg.rs1;
  assign vtype_csr   = {vtype_q.vill, {(vdisp_pkg::XLEN - 9){1'b0}}, vtype_q[7:0]};

  always_comb begin
    vtype_d    = vtype_q;
    vl_d       = vl_q;
    vstart_d   = vstart_q;
    cfg.result = '0;
    cfg.error  = 1'b0;

    if (opcode == vdisp_pkg::OPCODE_VEC) begin
      if (!cfg_form_ok) begin
        cfg.error = 1'b1;
      end else if (vtype_illegal) begin
        vtype_d = vdisp_pkg::VTYPE_RESET;
        vl_d    = '0;
      end else begin
        vtype_d = vtype_new;
        if (rs1_field == '0 && rd_field == '0) begin
          vl_d = vl_q;
        end else if (rs1_field == '0) begin
          vl_d = vlmax;
        end else begin
          // Stripmining
          vl_d = (cfg.rs1 > vlmax) ? vlmax : cfg.rs1;
        end
      end
      cfg.result = vl_d;
    end else begin
      case (csr_addr)
        vdisp_pkg::CSR_VSTART: begin
          cfg.result = vstart_q;
          case (func3[1:0])
            2'b01:   vstart_d = csr_operand;
            2'b10:   vstart_d = vstart_q | csr_operand;
            2'b11:   vstart_d = vstart_q & ~csr_operand;
            default: cfg.error = 1'b1;
          endcase
        end
        vdisp_pkg::CSR_VL, vdisp_pkg::CSR_VTYPE, vdisp_pkg::CSR_VLENB: begin
          // Read-only, only set/clear with rs1 = x0 is a plain read
          if (func3[1] && rs1_field == '0) begin
            if (csr_addr == vdisp_pkg::CSR_VL) begin
              cfg.result = vl_q;
            end else if (csr_addr == vdisp_pkg::CSR_VTYPE) begin
              cfg.result = vtype_csr;
            end else begin
              cfg.result = VLENB;
            end
          end else begin
            cfg.error = 1'b1;
          end
        end
        default: cfg.error = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vtype_q  <= vdisp_pkg::VTYPE_RESET;
      vl_q     <= '0;
      vstart_q <= '0;
    end else if (cfg.commit && cfg.cfg_sel) begin
      vtype_q  <= vtype_d;
      vl_q     <= vl_d;
      vstart_q <= vstart_d;
    end
  end

  assign cfg.vtype = vtype_q;
  assign cfg.vl    = vl_q;
  assign cfg.vill  = vtype_q.vill;

  // vl can never go past the largest VLMAX (SEW 8, LMUL 8)
  a_vl_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vl_q <= VLENB * 8);

endmodule

// File: rtl/vdisp_ctrl.sv
`timescale 1ns/1ps
// Dispatch control
// Decodes offloaded instructions, answers the core and registers backend requests

module vdisp_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  vcfg_if.ctrl                cfg,
  // Core request
  input  logic                acc_req_valid_i,
  input  logic [31:0]         acc_insn_i,
  input  vdisp_pkg::xlen_t    acc_rs1_i,
  input  vdisp_pkg::xlen_t    acc_rs2_i,
  input  logic [2:0]          acc_trans_id_i,
  output logic                acc_req_ready_o,
  // Core response
  output logic                acc_resp_valid_o,
  output vdisp_pkg::xlen_t    acc_resp_result_o,
  output logic                acc_resp_error_o,
  output logic [2:0]          acc_resp_trans_id_o,
  input  logic                acc_resp_ready_i,
  // Backend request
  output vdisp_pkg::vreq_t    vreq_o,
  output logic                vreq_valid_o,
  input  logic                vreq_ready_i
);

  logic [6:0]                 opcode;
  logic [2:0]                 func3;
  logic                       handle;
  logic                       is_cfg;
  logic                       is_arith;
  vdisp_pkg::varith_variant_e variant;
  vdisp_pkg::vop_e            dec_op;
  logic                       dec_illegal;
  vdisp_pkg::vreq_t           vreq_d;
  logic                       vreq_valid_d;

  assign opcode   = acc_insn_i[6:0];
  assign func3    = acc_insn_i[14:12];
  assign handle   = acc_req_valid_i && acc_resp_ready_i;
  assign is_cfg   = (opcode == vdisp_pkg::OPCODE_SYSTEM) ||
                    (opcode == vdisp_pkg::OPCODE_VEC && func3 == vdisp_pkg::F3_OPCFG);
  assign is_arith = (opcode == vdisp_pkg::OPCODE_VEC) &&
                    (func3 == vdisp_pkg::F3_OPIVV || func3 == vdisp_pkg::F3_OPIVX);
  assign variant  = (func3 == vdisp_pkg::F3_OPIVX) ? vdisp_pkg::VX : vdisp_pkg::VV;

  varith_decoder u_decoder (
    .func6_i   (acc_insn_i[31:26]),
    .variant_i (variant),
    .op_o      (dec_op),
    .illegal_o (dec_illegal)
  );

  // Configuration bus
  assign cfg.cfg_sel = is_cfg;
  assign cfg.commit  = acc_req_valid_i && acc_req_ready_o;
  assign cfg.insn    = acc_insn_i;
  assign cfg.rs1     = acc_rs1_i;
  assign cfg.rs2     = acc_rs2_i;

  // Backend payload, vl and vtype sampled at dispatch
  always_comb begin
    vreq_d.op            = dec_op;
    vreq_d.vs1           = acc_insn_i[19:15];
    vreq_d.use_vs1       = (variant == vdisp_pkg::VV);
    vreq_d.vs2           = acc_insn_i[24:20];
    vreq_d.vd            = acc_insn_i[11:7];
    vreq_d.scalar_op     = (variant == vdisp_pkg::VX) ? acc_rs1_i : '0;
    vreq_d.use_scalar_op = (variant == vdisp_pkg::VX);
    vreq_d.vm            = acc_insn_i[25];
    vreq_d.vl            = cfg.vl;
    vreq_d.vtype         = cfg.vtype;
  end

  always_comb begin
    acc_req_ready_o     = 1'b0;
    acc_resp_valid_o    = 1'b0;
    acc_resp_result_o   = '0;
    acc_resp_error_o    = 1'b0;
    acc_resp_trans_id_o = acc_trans_id_i;
    vreq_valid_d        = 1'b0;

    if (handle) begin
      if (is_cfg) begin
        // CSR state is local, always done in one cycle
        acc_req_ready_o   = 1'b1;
        acc_resp_valid_o  = 1'b1;
        acc_resp_result_o = cfg.result;
        acc_resp_error_o  = cfg.error;
      end else if (is_arith) begin
        // Accept only when the request register can load
        acc_req_ready_o  = vreq_ready_i;
        acc_resp_valid_o = vreq_ready_i;
        acc_resp_error_o = dec_illegal || cfg.vill;
        vreq_valid_d     = vreq_ready_i && !(dec_illegal || cfg.vill);
      end else begin
        acc_req_ready_o  = 1'b1;
        acc_resp_valid_o = 1'b1;
        acc_resp_error_o = 1'b1;
      end
    end
  end

  // Request register, frozen under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vreq_o       <= '0;
      vreq_valid_o <= 1'b0;
    end else if (vreq_ready_i) begin
      vreq_o       <= vreq_d;
      vreq_valid_o <= vreq_valid_d;
    end
  end

  a_resp_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_resp_valid_o |-> acc_resp_ready_i);

  a_vreq_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !vreq_ready_i |=> $stable(vreq_valid_o) && $stable(vreq_o));

endmodule

// File: rtl/vdisp_pkg.sv
// Vector dispatcher shared definitions
// Widths, opcodes, CSR addresses, vtype layout and the backend request format

package vdisp_pkg;

  // Scalar and element widths
  localparam int XLEN = 64;
  localparam int ELEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      vreg_t;

  // Element width encoding of vtype.vsew
  typedef enum logic [2:0] {
    EW8  = 3'd0,
    EW16 = 3'd1,
    EW32 = 3'd2,
    EW64 = 3'd3
  } vsew_e;

  // Internal vtype, the low 8 bits match the CSR layout
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    vsew_e      vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // Only vill set out of reset
  localparam vtype_t VTYPE_RESET = vtype_t'(9'h100);

  // Major opcodes
  localparam logic [6:0] OPCODE_VEC    = 7'h57;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // func3 groups under OPCODE_VEC
  localparam logic [2:0] F3_OPIVV = 3'd0;
  localparam logic [2:0] F3_OPIVX = 3'd4;
  localparam logic [2:0] F3_OPCFG = 3'd7;

  // Vector CSR addresses
  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

  // Operand source of an integer arithmetic instruction
  typedef enum logic {
    VV = 1'b0,
    VX = 1'b1
  } varith_variant_e;

  typedef enum logic [3:0] {
    VADD, VSUB, VRSUB, VMINU, VMIN, VMAXU, VMAX, VAND, VOR, VXOR
  } vop_e;

  // Request handed to the vector backend
  typedef struct packed {
    vop_e   op;
    vreg_t  vs1;
    logic   use_vs1;
    vreg_t  vs2;
    vreg_t  vd;
    xlen_t  scalar_op;
    logic   use_scalar_op;
    logic   vm;
    xlen_t  vl;
    vtype_t vtype;
  } vreq_t;

endpackage

// File: rtl/vdisp_top.sv
`timescale 1ns/1ps
// Vector instruction dispatcher top level
// Connects dispatch control and configuration unit, flattens the backend request

module vdisp_top #(
  parameter int Vlen = 128
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Core request and response
  input  logic                       acc_req_valid_i,
  input  logic [31:0]                acc_insn_i,
  input  vdisp_pkg::xlen_t           acc_rs1_i,
  input  vdisp_pkg::xlen_t           acc_rs2_i,
  input  logic [2:0]                 acc_trans_id_i,
  output logic                       acc_req_ready_o,
  output logic                       acc_resp_valid_o,
  output vdisp_pkg::xlen_t           acc_resp_result_o,
  output logic                       acc_resp_error_o,
  output logic [2:0]                 acc_resp_trans_id_o,
  input  logic                       acc_resp_ready_i,
  // Backend request
  output logic                       vreq_valid_o,
  output vdisp_pkg::vop_e            vreq_op_o,
  output vdisp_pkg::vreg_t           vreq_vs1_o,
  output logic                       vreq_use_vs1_o,
  output vdisp_pkg::vreg_t           vreq_vs2_o,
  output vdisp_pkg::vreg_t           vreq_vd_o,
  output vdisp_pkg::xlen_t           vreq_scalar_o,
  output logic                       vreq_use_scalar_o,
  output logic                       vreq_vm_o,
  output vdisp_pkg::xlen_t           vreq_vl_o,
  output vdisp_pkg::vtype_t          vreq_vtype_o,
  input  logic                       vreq_ready_i
);

  vdisp_pkg::vreq_t vreq;

  vcfg_if cfg_bus ();

  vcfg_unit #(
    .Vlen (Vlen)
  ) u_cfg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cfg    (cfg_bus.cfg)
  );

  vdisp_ctrl u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .cfg                 (cfg_bus.ctrl),
    .acc_req_valid_i     (acc_req_valid_i),
    .acc_insn_i          (acc_insn_i),
    .acc_rs1_i           (acc_rs1_i),
    .acc_rs2_i           (acc_rs2_i),
    .acc_trans_id_i      (acc_trans_id_i),
    .acc_req_ready_o     (acc_req_ready_o),
    .acc_resp_valid_o    (acc_resp_valid_o),
    .acc_resp_result_o   (acc_resp_result_o),
    .acc_resp_error_o    (acc_resp_error_o),
    .acc_resp_trans_id_o (acc_resp_trans_id_o),
    .acc_resp_ready_i    (acc_resp_ready_i),
    .vreq_o              (vreq),
    .vreq_valid_o        (vreq_valid_o),
    .vreq_ready_i        (vreq_ready_i)
  );

  // Request struct onto plain ports
  assign vreq_op_o         = vreq.op;
  assign vreq_vs1_o        = vreq.vs1;
  assign vreq_use_vs1_o    = vreq.use_vs1;
  assign vreq_vs2_o        = vreq.vs2;
  assign vreq_vd_o         = vreq.vd;
  assign vreq_scalar_o     = vreq.scalar_op;
  assign vreq_use_scalar_o = vreq.use_scalar_op;
  assign vreq_vm_o         = vreq.vm;
  assign vreq_vl_o         = vreq.vl;
  assign vreq_vtype_o      = vreq.vtype;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vector dispatcher testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f vdisp.f \
  --top-module vdisp_tb \
  -o vdisp_sim

./obj_dir/vdisp_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0

// File: vdisp.f
rtl/vdisp_pkg.sv
rtl/vcfg_if.sv
rtl/varith_decoder.sv
rtl/vcfg_unit.sv
rtl/vdisp_ctrl.sv
rtl/vdisp_top.sv
verification/vdisp_tb.sv

// File: verification/vdisp_tb.sv
`timescale 1ns/1ps
// Vector dispatcher testbench
// Directed tests for vsetvl(i), CSR access, arithmetic dispatch and back-pressure

module vdisp_tb;

  localparam int Vlen = 128;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [63:0] VTYPE_VILL = 64'h8000_0000_0000_0000;

  logic clk_i;
  logic rst_ni;
  logic acc_req_valid_i;
  logic [31:0] acc_insn_i;
  logic [63:0] acc_rs1_i;
  logic [63:0] acc_rs2_i;
  logic [2:0] acc_trans_id_i;
  logic acc_req_ready_o;
  logic acc_resp_valid_o;
  logic [63:0] acc_resp_result_o;
  logic acc_resp_error_o;
  logic [2:0] acc_resp_trans_id_o;
  logic acc_resp_ready_i;
  logic vreq_valid_o;
  vdisp_pkg::vop_e vreq_op_o;
  vdisp_pkg::vreg_t vreq_vs1_o;
  logic vreq_use_vs1_o;
  vdisp_pkg::vreg_t vreq_vs2_o;
  vdisp_pkg::vreg_t vreq_vd_o;
  logic [63:0] vreq_scalar_o;
  logic vreq_use_scalar_o;
  logic vreq_vm_o;
  logic [63:0] vreq_vl_o;
  vdisp_pkg::vtype_t vreq_vtype_o;
  logic vreq_ready_i;
  logic [159:0] vreq_bus;

  int seed = 31;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;
  logic [2:0] next_tid = 3'd0;
  logic [2:0] sent_tid;
  logic got_valid;
  logic got_error;
  logic [63:0] got_result;
  logic [2:0] got_tid;

  vdisp_top #(
    .Vlen (Vlen)
  ) DUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .acc_req_valid_i     (acc_req_valid_i),
    .acc_insn_i          (acc_insn_i),
    .acc_rs1_i           (acc_rs1_i),
    .acc_rs2_i           (acc_rs2_i),
    .acc_trans_id_i      (acc_trans_id_i),
    .acc_req_ready_o     (acc_req_ready_o),
    .acc_resp_valid_o    (acc_resp_valid_o),
    .acc_resp_result_o   (acc_resp_result_o),
    .acc_resp_error_o    (acc_resp_error_o),
    .acc_resp_trans_id_o (acc_resp_trans_id_o),
    .acc_resp_ready_i    (acc_resp_ready_i),
    .vreq_valid_o        (vreq_valid_o),
    .vreq_op_o           (vreq_op_o),
    .vreq_vs1_o          (vreq_vs1_o),
    .vreq_use_vs1_o      (vreq_use_vs1_o),
    .vreq_vs2_o          (vreq_vs2_o),
    .vreq_vd_o           (vreq_vd_o),
    .vreq_scalar_o       (vreq_scalar_o),
    .vreq_use_scalar_o   (vreq_use_scalar_o),
    .vreq_vm_o           (vreq_vm_o),
    .vreq_vl_o           (vreq_vl_o),
    .vreq_vtype_o        (vreq_vtype_o),
    .vreq_ready_i        (vreq_ready_i)
  );

  // All backend outputs in one word for stability checks
  assign vreq_bus = {vreq_valid_o, vreq_op_o, vreq_vs1_o, vreq_use_vs1_o, vreq_vs2_o,
                     vreq_vd_o, vreq_scalar_o, vreq_use_scalar_o, vreq_vm_o, vreq_vl_o,
                     vreq_vtype_o};

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Instruction encoders
  function automatic logic [31:0] vsetvli_word(input logic [7:0] vt, input logic [4:0] rs1f,
                                               input logic [4:0] rdf);
    return {4'b0000, vt, rs1f, 3'b111, rdf, 7'h57};
  endfunction

  function automatic logic [31:0] vsetvl_word(input logic [4:0] rs2f, input logic [4:0] rs1f,
                                              input logic [4:0] rdf);
    return {7'h40, rs2f, rs1f, 3'b111, rdf, 7'h57};
  endfunction

  function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [2:0] f3,
                                           input logic [4:0] rs1f, input logic [4:0] rdf);
    return {addr, rs1f, f3, rdf, 7'h73};
  endfunction

  function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic vm,
                                             input logic [4:0] vs2, input logic [4:0] vs1,
                                             input logic [2:0] f3, input logic [4:0] vd);
    return {f6, vm, vs2, vs1, f3, vd, 7'h57};
  endfunction

  // VLMAX = VLEN * LMUL / SEW, negative lmul for fractional
  function automatic logic [63:0] expected_vlmax(input int sew_code, input int lmul);
    int sew;
    sew = 8 << sew_code;
    if (lmul >= 0) begin
      return 64'((Vlen << lmul) / sew);
    end
    return 64'((Vlen >> (-lmul)) / sew);
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Called just after a falling edge, returns just after the falling edge past acceptance
  task automatic issue_insn(input logic [31:0] insn, input logic [63:0] rs1,
                            input logic [63:0] rs2);
    acc_req_valid_i = 1'b1;
    acc_insn_i      = insn;
    acc_rs1_i       = rs1;
    acc_rs2_i       = rs2;
    acc_trans_id_i  = next_tid;
    sent_tid        = next_tid;
    #1;
    while (!acc_req_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    got_valid  = acc_resp_valid_o;
    got_error  = acc_resp_error_o;
    got_result = acc_resp_result_o;
    got_tid    = acc_resp_trans_id_o;
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
    next_tid        = next_tid + 3'd1;
  endtask

  task automatic expect_resp(input logic exp_err, input logic [63:0] exp_res,
                             input logic chk_res);
    check_eq("acc_resp_valid_o", 64'(got_valid), 64'd1);
    check_eq("acc_resp_error_o", 64'(got_error), 64'(exp_err));
    check_eq("acc_resp_trans_id_o", 64'(got_tid), 64'(sent_tid));
    if (chk_res) begin
      check_eq("acc_resp_result_o", got_result, exp_res);
    end
  endtask

  // csrrs with rs1 = x0 is a plain read
  task automatic check_csr(input logic [11:0] addr, input logic [63:0] exp);
    issue_insn(csr_word(addr, 3'd2, 5'd0, 5'd1), 64'd0, 64'd0);
    expect_resp(1'b0, exp, 1'b1);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd0);
    check_eq("acc_req_ready_o", 64'(acc_req_ready_o), 64'd0);
    check_eq("acc_resp_valid_o", 64'(acc_resp_valid_o), 64'd0);
    check_csr(vdisp_pkg::CSR_VL, 64'd0);
    check_csr(vdisp_pkg::CSR_VTYPE, VTYPE_VILL);
    check_csr(vdisp_pkg::CSR_VLENB, 64'(Vlen / 8));
    check_csr(vdisp_pkg::CSR_VSTART, 64'd0);
    report_test("reset_state", e0);
  endtask

  task automatic vsetvli_stripmining();
    int e0;
    logic [31:0] r;
    logic [63:0] vals [6];
    logic [63:0] vmax;
    logic [63:0] exp;
    e0 = errors;
    vals[0] = 64'd3;
    vals[1] = 64'd20;
    for (int i = 2; i < 6; i++) begin
      r = $random(seed);
      vals[i] = {59'd0, r[4:0]};
    end
    // SEW 32, LMUL 2
    vmax = expected_vlmax(2, 1);
    for (int i = 0; i < 6; i++) begin
      issue_insn(vsetvli_word(8'h11, 5'd10, 5'd1), vals[i], 64'd0);
      exp = (vals[i] > vmax) ? vmax : vals[i];
      expect_resp(1'b0, exp, 1'b1);
      check_csr(vdisp_pkg::CSR_VL, exp);
    end
    issue_insn(vsetvli_word(8'h11, 5'd0, 5'd1), 64'd3, 64'd0);
    expect_resp(1'b0, vmax, 1'b1);
    check_csr(vdisp_pkg::CSR_VL, vmax);
    // SEW 8, LMUL 1/2
    vmax = expected_vlmax(0, -1);
    issue_insn(vsetvli_word(8'h07, 5'd10, 5'd1), 64'd100, 64'd0);
    expect_resp(1'b0, vmax, 1'b1);
    check_csr(vdisp_pkg::CSR_VL, vmax);
    check_csr(vdisp_pkg::CSR_VTYPE, 64'h07);
    report_test("vsetvli_stripmining", e0);
  endtask

  task automatic illegal_vtype();
    int e0;
    e0 = errors;
    // Reserved LMUL encoding
    issue_insn(vsetvl_word(5'd2, 5'd10, 5'd1), 64'd5, 64'h04);
    expect_resp(1'b0, 64'd0, 1'b1);
    check_csr(vdisp_pkg::CSR_VL, 64'd0);
    check_csr(vdisp_pkg::CSR_VTYPE, VTYPE_VILL);
    issue_insn(vsetvli_word(8'h11, 5'd10, 5'd1), 64'd5, 64'd0);
    expect_resp(1'b0, 64'd5, 1'b1);
    // SEW 64 at LMUL 1/2 needs ELEN 128
    issue_insn(vsetvl_word(5'd2, 5'd10, 5'd1), 64'd5, 64'h1F);
    expect_resp(1'b0, 64'd0, 1'b1);
    check_csr(vdisp_pkg::CSR_VL, 64'd0);
    check_csr(vdisp_pkg::CSR_VTYPE, VTYPE_VILL);
    issue_insn(arith_word(6'd0, 1'b1, 5'd2, 5'd3, vdisp_pkg::F3_OPIVV, 5'd4), 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd0);
    report_test("illegal_vtype", e0);
  endtask

  task automatic csr_rules();
    int e0;
    logic [63:0] vstart;
    e0 = errors;
    vstart = 64'd0;
    issue_insn(csr_word(vdisp_pkg::CSR_VSTART, 3'd1, 5'd2, 5'd1), 64'h5, 64'd0);
    expect_resp(1'b0, vstart, 1'b1);
    vstart = 64'h5;
    issue_insn(csr_word(vdisp_pkg::CSR_VSTART, 3'd1, 5'd2, 5'd1), 64'hA, 64'd0);
    expect_resp(1'b0, vstart, 1'b1);
    vstart = 64'hA;
    issue_insn(csr_word(vdisp_pkg::CSR_VSTART, 3'd6, 5'b10001, 5'd1), 64'd0, 64'd0);
    expect_resp(1'b0, vstart, 1'b1);
    vstart = vstart | 64'h11;
    issue_insn(csr_word(vdisp_pkg::CSR_VSTART, 3'd7, 5'b00011, 5'd1), 64'd0, 64'd0);
    expect_resp(1'b0, vstart, 1'b1);
    vstart = vstart & ~64'h3;
    check_csr(vdisp_pkg::CSR_VSTART, vstart);
    issue_insn(csr_word(vdisp_pkg::CSR_VSTART, 3'd5, 5'd0, 5'd0), 64'd0, 64'd0);
    expect_resp(1'b0, vstart, 1'b1);
    // Read-only CSRs and an unknown address
    issue_insn(csr_word(vdisp_pkg::CSR_VL, 3'd1, 5'd2, 5'd1), 64'd7, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    issue_insn(csr_word(vdisp_pkg::CSR_VTYPE, 3'd2, 5'd3, 5'd1), 64'd7, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    issue_insn(csr_word(12'h123, 3'd2, 5'd0, 5'd1), 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    report_test("csr_rules", e0);
  endtask

  task automatic arith_dispatch();
    int e0;
    logic [5:0] f6_tab [10] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd9, 6'd10, 6'd11};
    vdisp_pkg::vop_e op_tab [10] = '{vdisp_pkg::VADD, vdisp_pkg::VSUB, vdisp_pkg::VRSUB,
                                     vdisp_pkg::VMINU, vdisp_pkg::VMIN, vdisp_pkg::VMAXU,
                                     vdisp_pkg::VMAX, vdisp_pkg::VAND, vdisp_pkg::VOR,
                                     vdisp_pkg::VXOR};
    logic [2:0] f3;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic [4:0] vd;
    logic vm;
    logic [63:0] rs1;
    e0 = errors;
    // SEW 32, LMUL 2, vl 6
    issue_insn(vsetvli_word(8'h11, 5'd10, 5'd1), 64'd6, 64'd0);
    expect_resp(1'b0, 64'd6, 1'b1);
    for (int i = 0; i < 10; i++) begin
      for (int v = 0; v < 2; v++) begin
        if (!(i == 2 && v == 0)) begin
          f3  = (v == 1) ? vdisp_pkg::F3_OPIVX : vdisp_pkg::F3_OPIVV;
          vs1 = 5'(i + 1);
          vs2 = 5'(i + 12);
          vd  = 5'(31 - i);
          vm  = 1'(i % 2);
          rs1 = {$random(seed), $random(seed)};
          issue_insn(arith_word(f6_tab[i], vm, vs2, vs1, f3, vd), rs1, 64'd0);
          expect_resp(1'b0, 64'd0, 1'b0);
          check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd1);
          check_eq("vreq_op_o", 64'(vreq_op_o), 64'(op_tab[i]));
          check_eq("vreq_vs2_o", 64'(vreq_vs2_o), 64'(vs2));
          check_eq("vreq_vd_o", 64'(vreq_vd_o), 64'(vd));
          check_eq("vreq_vm_o", 64'(vreq_vm_o), 64'(vm));
          check_eq("vreq_vl_o", vreq_vl_o, 64'd6);
          check_eq("vreq_vtype_o", 64'(vreq_vtype_o), 64'h011);
          check_eq("vreq_use_vs1_o", 64'(vreq_use_vs1_o), 64'(v == 0));
          check_eq("vreq_use_scalar_o", 64'(vreq_use_scalar_o), 64'(v == 1));
          if (v == 0) begin
            check_eq("vreq_vs1_o", 64'(vreq_vs1_o), 64'(vs1));
          end else begin
            check_eq("vreq_scalar_o", vreq_scalar_o, rs1);
          end
        end
      end
    end
    // rsub.vv, undefined func6, OPIVI group and a scalar opcode
    issue_insn(arith_word(6'd3, 1'b1, 5'd1, 5'd2, vdisp_pkg::F3_OPIVV, 5'd3), 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd0);
    issue_insn(arith_word(6'h3F, 1'b1, 5'd1, 5'd2, vdisp_pkg::F3_OPIVX, 5'd3), 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd0);
    issue_insn(arith_word(6'd0, 1'b1, 5'd1, 5'd2, 3'd3, 5'd3), 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    issue_insn(32'h0000_0033, 64'd0, 64'd0);
    expect_resp(1'b1, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd0);
    report_test("arith_dispatch", e0);
  endtask

  task automatic backpressure();
    int e0;
    logic [159:0] snap;
    logic [31:0] insn_b;
    e0 = errors;
    issue_insn(arith_word(6'd0, 1'b1, 5'd4, 5'd5, vdisp_pkg::F3_OPIVX, 5'd6), 64'h55, 64'd0);
    expect_resp(1'b0, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd1);
    vreq_ready_i = 1'b0;
    snap = vreq_bus;
    insn_b = arith_word(6'd11, 1'b0, 5'd7, 5'd8, vdisp_pkg::F3_OPIVX, 5'd9);
    acc_req_valid_i = 1'b1;
    acc_insn_i      = insn_b;
    acc_rs1_i       = 64'h1234;
    acc_trans_id_i  = next_tid;
    for (int k = 0; k < 3; k++) begin
      #1;
      check_eq("acc_req_ready_o", 64'(acc_req_ready_o), 64'd0);
      check_eq("acc_resp_valid_o", 64'(acc_resp_valid_o), 64'd0);
      @(negedge clk_i);
    end
    acc_req_valid_i = 1'b0;
    // Configuration side still answers while the backend stalls
    check_csr(vdisp_pkg::CSR_VL, 64'd6);
    assert (vreq_bus === snap)
    else begin
      $display("error: vreq outputs = 0x%0h, expected 0x%0h", vreq_bus, snap);
      errors++;
    end
    vreq_ready_i = 1'b1;
    issue_insn(insn_b, 64'h1234, 64'd0);
    expect_resp(1'b0, 64'd0, 1'b0);
    check_eq("vreq_valid_o", 64'(vreq_valid_o), 64'd1);
    check_eq("vreq_op_o", 64'(vreq_op_o), 64'(vdisp_pkg::VXOR));
    check_eq("vreq_scalar_o", vreq_scalar_o, 64'h1234);
    report_test("backpressure", e0);
  endtask

  // Run limit, far above the length of all tests
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst_ni           = 1'b0;
    acc_req_valid_i  = 1'b0;
    acc_insn_i       = 32'd0;
    acc_rs1_i        = 64'd0;
    acc_rs2_i        = 64'd0;
    acc_trans_id_i   = 3'd0;
    acc_resp_ready_i = 1'b1;
    vreq_ready_i     = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    reset_state();
    vsetvli_stripmining();
    illegal_vtype();
    csr_rules();
    arith_dispatch();
    backpressure();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
